// File: dcache_macros.svh
// memory size and cache geometry constants, included by the RTL and the testbench
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// backing memory is 4 KiB, byte addressed
`define DMEM_ADDR_BITS 12

// 16 lines of 8 bytes each
`define DC_LINES       16
`define DC_INDEX_BITS  4
`define DC_OFFSET_BITS 3

// whatever is left of the memory address above index and offset
`define DC_TAG_BITS    (`DMEM_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS)

// hit and miss counters saturate at this width
`define CNT_BITS       16

`endif

// File: mem_pkg.sv
// core memory operation types, shared by the cache controller, memory and testbench
`default_nettype none

package mem_pkg;

    // operations the core can strobe in
    typedef enum logic [2:0] {
        OP_NONE        = 3'd0,
        OP_LOAD_WORD   = 3'd1,
        OP_LOAD_BYTE   = 3'd2, // unsigned
        OP_STORE_WORD  = 3'd3,
        OP_STORE_BYTE  = 3'd4
    } mem_op_e;

    // write kind seen by the backing memory
    typedef enum logic [1:0] {
        WE_NONE = 2'd0,
        WE_WORD = 2'd1,
        WE_BYTE = 2'd2
    } mem_we_e;

    function automatic logic op_is_load(input mem_op_e op);
        return (op == OP_LOAD_WORD) || (op == OP_LOAD_BYTE);
    endfunction

    function automatic logic op_is_store(input mem_op_e op);
        return (op == OP_STORE_WORD) || (op == OP_STORE_BYTE);
    endfunction

    // memory write kind for a store op
    function automatic mem_we_e op_we(input mem_op_e op);
        case (op)
            OP_STORE_WORD: return WE_WORD;
            OP_STORE_BYTE: return WE_BYTE;
            default:       return WE_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: cache_pkg.sv
// cache controller state and configuration register map, used by the cache blocks and testbench
`default_nettype none

package cache_pkg;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0, // only state that accepts requests
        ST_REFILL = 2'd1,
        ST_STORE  = 2'd2,
        ST_DONE   = 2'd3
    } ctrl_state_e;

    // register addresses on the config port
    // REG_CTRL bit 0 is enable, bit 1 is a self-clearing flush
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_HITS   = 2'd1, // any write clears
        REG_MISSES = 2'd2  // any write clears
    } cfg_reg_e;

endpackage

`default_nettype wire

// File: data_mem.sv
// byte-addressed backing memory behind the data cache, written through by dcache_ctrl
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module data_mem (
    input  logic              clk,
    input  mem_pkg::mem_we_e  mem_we,
    input  logic [31:0]       mem_addr,
    input  logic [31:0]       mem_wdata,
    output logic [63:0]       mem_line,
    output logic              mem_ready
);

    logic [7:0] mem_array [2**`DMEM_ADDR_BITS];

    logic [`DMEM_ADDR_BITS-1:0] byte_addr;
    logic [`DMEM_ADDR_BITS-1:0] word_base;
    logic [`DMEM_ADDR_BITS-1:0] line_base;

    assign byte_addr = mem_addr[`DMEM_ADDR_BITS-1:0];
    assign word_base = {mem_addr[`DMEM_ADDR_BITS-1:2], 2'b00}; // bits 1:0 ignored
    assign line_base = {mem_addr[`DMEM_ADDR_BITS-1:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};

    // whole aligned line, byte 0 in the low bits
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            mem_line[i*8 +: 8] = mem_array[line_base + `DMEM_ADDR_BITS'(i)];
        end
    end

    always_ff @(posedge clk) begin
        case (mem_we)
            mem_pkg::WE_WORD: begin
                for (int k = 0; k < 4; k++) begin
                    mem_array[word_base + `DMEM_ADDR_BITS'(k)] <= mem_wdata[k*8 +: 8];
                end
            end
            mem_pkg::WE_BYTE: begin
                mem_array[byte_addr] <= mem_wdata[7:0];
            end
            default: ;
        endcase
    end

    // low for one cycle after each write, then back high
    always_ff @(posedge clk) begin
        mem_ready <= (mem_we == mem_pkg::WE_NONE);
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
// direct-mapped write-through data cache controller between the core port and data_mem
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  mem_pkg::mem_op_e  op,
    input  logic [31:0]       addr,
    input  logic [31:0]       wdata,
    output logic              ready,
    output logic              done,
    output logic [31:0]       rdata,
    input  logic              cache_en,
    input  logic              flush,
    output logic              hit_pulse,
    output logic              miss_pulse,
    output mem_pkg::mem_we_e  mem_we,
    output logic [31:0]       mem_addr,
    output logic [31:0]       mem_wdata,
    input  logic [63:0]       mem_line,
    input  logic              mem_ready
);

    cache_pkg::ctrl_state_e state;

    logic [`DC_LINES-1:0]    valid;
    logic [`DC_TAG_BITS-1:0] tag_arr  [`DC_LINES];
    logic [63:0]             data_arr [`DC_LINES];

    // request latched on acceptance
    logic [31:0]      addr_q;
    logic [31:0]      wdata_q;
    mem_pkg::mem_op_e op_q;
    logic             store_hit_q;
    logic             wr_sent; // store already handed to memory

    logic [`DC_INDEX_BITS-1:0] req_idx;
    logic [`DC_TAG_BITS-1:0]   req_tag;
    logic [`DC_INDEX_BITS-1:0] q_idx;
    logic [`DC_TAG_BITS-1:0]   q_tag;
    logic tag_match;
    logic load_hit;
    logic accept;
    logic acc_load;
    logic acc_store;
    logic store_end;

    // word or zero-extended byte out of a line
    function automatic logic [31:0] pick(input logic [63:0] line,
                                         input logic [`DC_OFFSET_BITS-1:0] off,
                                         input logic is_byte);
        logic [31:0] word;
        word = off[2] ? line[63:32] : line[31:0];
        if (is_byte) begin
            return {24'b0, word[{off[1:0], 3'b000} +: 8]};
        end
        return word;
    endfunction

    assign req_idx = addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_tag = addr[`DC_OFFSET_BITS + `DC_INDEX_BITS +: `DC_TAG_BITS];
    assign q_idx   = addr_q[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign q_tag   = addr_q[`DC_OFFSET_BITS + `DC_INDEX_BITS +: `DC_TAG_BITS];

    // stores patch a matching line even with the cache off, so it never goes stale
    assign tag_match = valid[req_idx] && (tag_arr[req_idx] == req_tag);
    assign load_hit  = cache_en && tag_match;

    assign accept    = req && (state == cache_pkg::ST_IDLE);
    assign acc_load  = accept && mem_pkg::op_is_load(op);
    assign acc_store = accept && mem_pkg::op_is_store(op);

    assign hit_pulse  = acc_load && load_hit;
    assign miss_pulse = acc_load && !load_hit;

    assign store_end = (state == cache_pkg::ST_STORE) && wr_sent && mem_ready;
    assign ready     = (state == cache_pkg::ST_IDLE);
    assign done      = (state == cache_pkg::ST_DONE) || store_end;

    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;
    assign mem_we    = ((state == cache_pkg::ST_STORE) && !wr_sent) ?
                       mem_pkg::op_we(op_q) : mem_pkg::WE_NONE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= cache_pkg::ST_IDLE;
            valid   <= '0;
            wr_sent <= 1'b0;
        end else begin
            case (state)
                cache_pkg::ST_IDLE: begin
                    if (acc_load) begin
                        state <= load_hit ? cache_pkg::ST_DONE : cache_pkg::ST_REFILL;
                    end else if (acc_store) begin
                        state <= cache_pkg::ST_STORE;
                    end
                end
                cache_pkg::ST_REFILL: begin
                    if (cache_en) begin
                        valid[q_idx] <= 1'b1; // no allocation while disabled
                    end
                    state <= cache_pkg::ST_DONE;
                end
                cache_pkg::ST_STORE: begin
                    wr_sent <= 1'b1;
                    if (store_end) begin
                        wr_sent <= 1'b0;
                        state   <= cache_pkg::ST_IDLE;
                    end
                end
                default: state <= cache_pkg::ST_IDLE; // ST_DONE
            endcase
            if (flush) begin
                valid <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q      <= addr;
            wdata_q     <= wdata;
            op_q        <= op;
            store_hit_q <= tag_match;
        end
        if (acc_load && load_hit) begin
            rdata <= pick(data_arr[req_idx], addr[`DC_OFFSET_BITS-1:0],
                          op == mem_pkg::OP_LOAD_BYTE);
        end
        if (state == cache_pkg::ST_REFILL) begin
            rdata <= pick(mem_line, addr_q[`DC_OFFSET_BITS-1:0],
                          op_q == mem_pkg::OP_LOAD_BYTE);
            if (cache_en) begin
                data_arr[q_idx] <= mem_line;
                tag_arr[q_idx]  <= q_tag;
            end
        end
        // patch the cached copy in the same cycle the write goes out
        if ((state == cache_pkg::ST_STORE) && !wr_sent && store_hit_q) begin
            if (op_q == mem_pkg::OP_STORE_BYTE) begin
                data_arr[q_idx][{addr_q[2:0], 3'b000} +: 8] <= wdata_q[7:0];
            end else begin
                data_arr[q_idx][{addr_q[2], 5'b00000} +: 32] <= wdata_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_cfg.sv
// cache configuration and load statistics registers, sits beside dcache_ctrl under the top
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_cfg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_we,
    input  cache_pkg::cfg_reg_e  cfg_addr,
    input  logic [31:0]          cfg_wdata,
    output logic [31:0]          cfg_rdata,
    output logic                 cache_en,
    output logic                 flush,
    input  logic                 hit_pulse,
    input  logic                 miss_pulse
);

    logic                 en_q;
    logic                 flush_q;
    logic [`CNT_BITS-1:0] hits;
    logic [`CNT_BITS-1:0] misses;

    logic ctrl_wr;
    logic hits_clr;
    logic misses_clr;

    assign ctrl_wr    = cfg_we && (cfg_addr == cache_pkg::REG_CTRL);
    assign hits_clr   = cfg_we && (cfg_addr == cache_pkg::REG_HITS);
    assign misses_clr = cfg_we && (cfg_addr == cache_pkg::REG_MISSES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q    <= 1'b1; // cache comes up enabled
            flush_q <= 1'b0;
            hits    <= '0;
            misses  <= '0;
        end else begin
            flush_q <= ctrl_wr && cfg_wdata[1]; // one cycle only
            if (ctrl_wr) begin
                en_q <= cfg_wdata[0];
            end
            if (hits_clr) begin
                hits <= '0;
            end else if (hit_pulse && (hits != '1)) begin
                hits <= hits + 1'b1;
            end
            if (misses_clr) begin
                misses <= '0;
            end else if (miss_pulse && (misses != '1)) begin
                misses <= misses + 1'b1;
            end
        end
    end

    assign cache_en = en_q;
    assign flush    = flush_q;

    // flush bit reads back as zero
    always_comb begin
        case (cfg_addr)
            cache_pkg::REG_CTRL:   cfg_rdata = {31'b0, en_q};
            cache_pkg::REG_HITS:   cfg_rdata = 32'(hits);
            cache_pkg::REG_MISSES: cfg_rdata = 32'(misses);
            default:               cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
// data cache subsystem top, instantiated by the testbench as the core-side memory port
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  mem_pkg::mem_op_e     op,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output logic                 ready,
    output logic                 done,
    output logic [31:0]          rdata,
    input  logic                 cfg_we,
    input  cache_pkg::cfg_reg_e  cfg_addr,
    input  logic [31:0]          cfg_wdata,
    output logic [31:0]          cfg_rdata
);

    // config to controller
    logic cache_en;
    logic flush;
    logic hit_pulse;
    logic miss_pulse;

    // controller to memory
    mem_pkg::mem_we_e mem_we;
    logic [31:0]      mem_addr;
    logic [31:0]      mem_wdata;
    logic [63:0]      mem_line;
    logic             mem_ready;

    dcache_ctrl ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .ready      (ready),
        .done       (done),
        .rdata      (rdata),
        .cache_en   (cache_en),
        .flush      (flush),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_line   (mem_line),
        .mem_ready  (mem_ready)
    );

    dcache_cfg cfg0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cache_en   (cache_en),
        .flush      (flush),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse)
    );

    data_mem mem0 (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_line  (mem_line),
        .mem_ready (mem_ready)
    );

endmodule

`default_nettype wire

// File: tb_dcache.sv
// table-driven testbench for dcache_top, checks loads against a byte-array model and hit predictor
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module tb_dcache;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 3;

    typedef enum logic [2:0] {
        CFG_NONE, CFG_FLUSH, CFG_DISABLE, CFG_ENABLE, CFG_CLR_HITS
    } cfg_act_e;

    typedef struct packed {
        mem_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        cfg_act_e         cfg;     // applied before the op
        logic             chk_cnt; // read back counters afterwards
    } entry_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                req;
    mem_pkg::mem_op_e    op;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic                ready;
    logic                done;
    logic [31:0]         rdata;
    logic                cfg_we;
    cache_pkg::cfg_reg_e cfg_addr;
    logic [31:0]         cfg_wdata;
    logic [31:0]         cfg_rdata;

    entry_t tbl[$];
    string  names[$];
    bit     table_ready = 1'b0;

    // reference model state
    logic [7:0]              ref_mem [2**`DMEM_ADDR_BITS];
    logic [`DC_LINES-1:0]    pv;
    logic [`DC_TAG_BITS-1:0] pt [`DC_LINES];
    logic                    en_model;
    int                      exp_hits;
    int                      exp_misses;

    int          errors = 0;
    int          checks = 0;

    dcache_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic void add_entry(input string name, input mem_pkg::mem_op_e o,
                                      input logic [31:0] a, input cfg_act_e c, input logic chk);
        entry_t e;
        e.op      = o;
        e.addr    = a;
        e.wdata   = $urandom;
        e.cfg     = c;
        e.chk_cnt = chk;
        tbl.push_back(e);
        names.push_back(name);
    endfunction

    function automatic logic [31:0] model_load(input mem_pkg::mem_op_e o, input logic [31:0] a);
        if (o == mem_pkg::OP_LOAD_BYTE) begin
            return {24'b0, ref_mem[a[`DMEM_ADDR_BITS-1:0]]}; // zero-extended
        end
        return {ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd3}], ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd2}],
                ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd1}], ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd0}]};
    endfunction

    function automatic void model_store(input mem_pkg::mem_op_e o, input logic [31:0] a,
                                        input logic [31:0] d);
        if (o == mem_pkg::OP_STORE_BYTE) begin
            ref_mem[a[`DMEM_ADDR_BITS-1:0]] = d[7:0];
        end else begin
            ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd0}] = d[7:0];
            ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd1}] = d[15:8];
            ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd2}] = d[23:16];
            ref_mem[{a[`DMEM_ADDR_BITS-1:2], 2'd3}] = d[31:24];
        end
    endfunction

    // returns expected load latency, bumps the expected counters
    function automatic int predict_load(input logic [31:0] a);
        logic [`DC_INDEX_BITS-1:0] idx;
        logic [`DC_TAG_BITS-1:0]   tag;
        idx = a[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
        tag = a[`DC_OFFSET_BITS + `DC_INDEX_BITS +: `DC_TAG_BITS];
        if (en_model && pv[idx] && (pt[idx] == tag)) begin
            exp_hits++;
            return 1;
        end
        exp_misses++;
        if (en_model) begin
            pv[idx] = 1'b1; // refill allocates only while enabled
            pt[idx] = tag;
        end
        return 2;
    endfunction

    task automatic write_cfg(input cache_pkg::cfg_reg_e r, input logic [31:0] v);
        cfg_addr  = r;
        cfg_wdata = v;
        cfg_we    = 1'b1;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        @(posedge clk); // flush pulse lands here
        #1;
    endtask

    task automatic read_cfg(input cache_pkg::cfg_reg_e r, output logic [31:0] v);
        cfg_addr = r;
        @(negedge clk);
        v = cfg_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic check_counters(input string name);
        logic [31:0] v;
        read_cfg(cache_pkg::REG_HITS, v);
        check_val({name, " hits"}, 32'(exp_hits), v);
        read_cfg(cache_pkg::REG_MISSES, v);
        check_val({name, " misses"}, 32'(exp_misses), v);
    endtask

    task automatic apply_cfg(input cfg_act_e c);
        case (c)
            CFG_FLUSH: begin
                write_cfg(cache_pkg::REG_CTRL, {30'b0, 1'b1, en_model});
                pv = '0;
            end
            CFG_DISABLE: begin
                en_model = 1'b0;
                write_cfg(cache_pkg::REG_CTRL, 32'h0);
            end
            CFG_ENABLE: begin
                en_model = 1'b1;
                write_cfg(cache_pkg::REG_CTRL, 32'h1);
            end
            CFG_CLR_HITS: begin
                write_cfg(cache_pkg::REG_HITS, 32'hffff_ffff);
                exp_hits = 0;
            end
            default: ;
        endcase
    endtask

    // strobe one request, count cycles from acceptance to done
    task automatic issue_op(input mem_pkg::mem_op_e o, input logic [31:0] a, input logic [31:0] d,
                            output logic [31:0] got, output int lat);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        req   = 1'b1;
        op    = o;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #1;
        req = 1'b0;
        op  = mem_pkg::OP_NONE;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!done);
        got = rdata;
        @(posedge clk);
        #1;
    endtask

    function automatic void build_table();
        add_entry("st_word_a0", mem_pkg::OP_STORE_WORD, 32'h040, CFG_NONE, 1'b0);
        add_entry("st_word_a4", mem_pkg::OP_STORE_WORD, 32'h044, CFG_NONE, 1'b0);
        add_entry("ld_word_a0_miss", mem_pkg::OP_LOAD_WORD, 32'h040, CFG_NONE, 1'b1);
        add_entry("ld_word_a4_hit", mem_pkg::OP_LOAD_WORD, 32'h044, CFG_NONE, 1'b0);
        add_entry("ld_word_a0_hit", mem_pkg::OP_LOAD_WORD, 32'h040, CFG_NONE, 1'b1);
        add_entry("st_byte_a5_cached", mem_pkg::OP_STORE_BYTE, 32'h045, CFG_NONE, 1'b0);
        add_entry("ld_word_a4_merged", mem_pkg::OP_LOAD_WORD, 32'h044, CFG_NONE, 1'b0);
        add_entry("ld_byte_a5", mem_pkg::OP_LOAD_BYTE, 32'h045, CFG_NONE, 1'b0);
        add_entry("ld_byte_a7", mem_pkg::OP_LOAD_BYTE, 32'h047, CFG_NONE, 1'b1);
        // same index as a0, tag 1
        add_entry("st_word_b0", mem_pkg::OP_STORE_WORD, 32'h0c0, CFG_NONE, 1'b0);
        add_entry("st_word_b4", mem_pkg::OP_STORE_WORD, 32'h0c4, CFG_NONE, 1'b0);
        add_entry("ld_word_b4_evict", mem_pkg::OP_LOAD_WORD, 32'h0c4, CFG_NONE, 1'b1);
        add_entry("ld_word_a0_again", mem_pkg::OP_LOAD_WORD, 32'h040, CFG_NONE, 1'b1);
        add_entry("st_byte_b2_uncached", mem_pkg::OP_STORE_BYTE, 32'h0c2, CFG_NONE, 1'b0);
        add_entry("ld_word_b0_merged", mem_pkg::OP_LOAD_WORD, 32'h0c0, CFG_NONE, 1'b0);
        add_entry("ld_byte_b2", mem_pkg::OP_LOAD_BYTE, 32'h0c2, CFG_NONE, 1'b1);
        add_entry("st_word_c0", mem_pkg::OP_STORE_WORD, 32'h100, CFG_NONE, 1'b0);
        add_entry("ld_word_c0", mem_pkg::OP_LOAD_WORD, 32'h100, CFG_NONE, 1'b0);
        add_entry("flush", mem_pkg::OP_NONE, 32'h0, CFG_FLUSH, 1'b1);
        add_entry("ld_word_c0_flushed", mem_pkg::OP_LOAD_WORD, 32'h100, CFG_NONE, 1'b1);
        add_entry("ld_word_b0_flushed", mem_pkg::OP_LOAD_WORD, 32'h0c0, CFG_NONE, 1'b0);
        add_entry("disable", mem_pkg::OP_NONE, 32'h0, CFG_DISABLE, 1'b0);
        add_entry("ld_word_c0_off", mem_pkg::OP_LOAD_WORD, 32'h100, CFG_NONE, 1'b0);
        add_entry("ld_byte_b2_off", mem_pkg::OP_LOAD_BYTE, 32'h0c2, CFG_NONE, 1'b0);
        // other tag at index 8, must not replace the b line
        add_entry("ld_word_a0_off", mem_pkg::OP_LOAD_WORD, 32'h040, CFG_NONE, 1'b0);
        add_entry("st_word_c0_off", mem_pkg::OP_STORE_WORD, 32'h100, CFG_NONE, 1'b0);
        add_entry("ld_word_c0_off2", mem_pkg::OP_LOAD_WORD, 32'h100, CFG_NONE, 1'b1);
        add_entry("enable", mem_pkg::OP_NONE, 32'h0, CFG_ENABLE, 1'b0);
        add_entry("ld_word_c0_on", mem_pkg::OP_LOAD_WORD, 32'h100, CFG_NONE, 1'b1);
        add_entry("ld_word_b0_on", mem_pkg::OP_LOAD_WORD, 32'h0c0, CFG_NONE, 1'b1);
        add_entry("clr_hits", mem_pkg::OP_NONE, 32'h0, CFG_CLR_HITS, 1'b1);
        add_entry("ld_byte_c3_on", mem_pkg::OP_LOAD_BYTE, 32'h103, CFG_NONE, 1'b1);
    endfunction

    initial begin
        entry_t      e;
        logic [31:0] got;
        logic [31:0] exp_val;
        int          lat;
        int          exp_lat;
        void'($urandom(32'h78c74d57));
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = mem_pkg::OP_NONE;
        addr       = '0;
        wdata      = '0;
        cfg_we     = 1'b0;
        cfg_addr   = cache_pkg::REG_CTRL;
        cfg_wdata  = '0;
        pv         = '0;
        en_model   = 1'b1;
        exp_hits   = 0;
        exp_misses = 0;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("reset ready", 32'h1, {31'b0, ready});
        check_val("reset done", 32'h0, {31'b0, done});
        @(posedge clk);
        #1;
        check_counters("reset");
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            apply_cfg(e.cfg);
            if (e.op == mem_pkg::OP_LOAD_WORD || e.op == mem_pkg::OP_LOAD_BYTE) begin
                exp_val = model_load(e.op, e.addr);
                exp_lat = predict_load(e.addr);
                issue_op(e.op, e.addr, e.wdata, got, lat);
                check_val(names[i], exp_val, got);
                check_val({names[i], " latency"}, 32'(exp_lat), 32'(lat));
            end else if (e.op == mem_pkg::OP_STORE_WORD || e.op == mem_pkg::OP_STORE_BYTE) begin
                model_store(e.op, e.addr, e.wdata);
                issue_op(e.op, e.addr, e.wdata, got, lat);
                check_val({names[i], " latency"}, 32'd3, 32'(lat)); // done after mem_ready
            end
            if (e.chk_cnt) begin
                check_counters(names[i]);
            end
        end
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // generous per-entry budget, no entry needs more than about 8 cycles
    initial begin
        wait (table_ready);
        repeat (RST_CYCLES + 10 * tbl.size() + 10) @(posedge clk);
        $display("timeout: the DUT did not get through %0d table entries in time", tbl.size());
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mem_pkg.sv
cache_pkg.sv
data_mem.sv
dcache_ctrl.sv
dcache_cfg.sv
dcache_top.sv
tb_dcache.sv

// File: Makefile
all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module tb_dcache -o tb_dcache

run: compile
	@out="$$(./obj_dir/tb_dcache)"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
